/* txPkg.sv */
package txPkg;
	localparam int chanCount = 8;	// transducer channels on the board

	typedef logic [8:0] chargeTime_t;	// pulse high time, in cycles
	typedef logic [15:0] phaseDelay_t;	// launch to pulse start
	typedef logic [22:0] fireDelay_t;	// fire command to launch
	typedef logic [31:0] recvDelay_t;	// issue command to trigger line high
	typedef logic [31:0] apbData_t;
	typedef logic [3:0] apbAddr_t;	// word address
	typedef logic [8:0] cmdWord_t;

	// codes 2 and 3 behave like idle
	typedef enum logic [1:0] {modeIdle = 2'b00, modePio = 2'b01} ctrlMode_e;
	typedef enum logic [1:0] {fireIdle, fireDelay, fireActive} fireState_e;

	typedef struct packed {
		logic fire;
		logic issueRecvTrig;
		logic setAmp;
		logic setPhase;
		logic resetRecvTrig;
		logic resetInterrupt;
	} txCmd_t;

	// flag positions inside the command register
	localparam int cmdBitIssueRecvTrig = 1;
	localparam int cmdBitFire = 2;
	localparam int cmdBitSetAmp = 4;
	localparam int cmdBitSetPhase = 5;
	localparam int cmdBitResetRecvTrig = 6;
	localparam int cmdBitResetInterrupt = 7;

	localparam apbAddr_t regControl = 4'd0;
	localparam apbAddr_t regActiveMask = 4'd1;
	localparam apbAddr_t regCommand = 4'd2;
	localparam apbAddr_t regPhase01 = 4'd3;	// then 23, 45, 67 at 4..6
	localparam apbAddr_t regChargeFire = 4'd7;
	localparam apbAddr_t regRecvDelay = 4'd8;
	localparam apbAddr_t regStatus = 4'd9;

	typedef struct packed {
		chargeTime_t chargeTime;
		fireDelay_t fireDelay;
		recvDelay_t recvTrigDelay;
		logic [chanCount-1:0] activeMask;
		phaseDelay_t [chanCount-1:0] phaseDelay;
	} txSettings_t;
endpackage

/* apbRegFile.sv */
module apbRegFile
(
	input logic txCLK,
	input logic rst,
	input logic pSel,
	input logic pEnable,
	input logic pWrite,
	input txPkg::apbAddr_t pAddr,
	input txPkg::apbData_t pWdata,
	output txPkg::apbData_t pRdata,
	output logic pReady,
	output logic pSlvErr,
	input logic busy,
	input logic interrupt,
	input logic adcTrigger,
	output txPkg::ctrlMode_e mode,
	output txPkg::txSettings_t settings,
	output txPkg::cmdWord_t cmdWord
);
	import txPkg::*;

	logic [1:0] ctrlReg;	// raw mode bits, read back as written
	logic access;
	logic wrEn;

	assign access = pSel && pEnable;
	assign pReady = 1'b1;	// zero wait states
	assign pSlvErr = access && (pAddr > regStatus || (pWrite && pAddr == regStatus));
	assign wrEn = access && pWrite && !pSlvErr;
	assign mode = ctrlMode_e'(ctrlReg);

	always_ff @(posedge txCLK)
	begin
		if (rst)
		begin
			ctrlReg <= modeIdle;
			settings <= '0;
			cmdWord <= '0;
		end
		else if (wrEn)
		begin
			case (pAddr)
				regControl: ctrlReg <= pWdata[1:0];
				regActiveMask: settings.activeMask <= pWdata[chanCount-1:0];
				regCommand: cmdWord <= pWdata[$bits(cmdWord_t)-1:0];
				regChargeFire:
				begin
					settings.chargeTime <= pWdata[8:0];	// amplitude in the low bits
					settings.fireDelay <= pWdata[31:9];
				end
				regRecvDelay: settings.recvTrigDelay <= pWdata;
				default: ;
			endcase
			// two channels per phase register, even channel low
			for (int i = 0; i < chanCount / 2; i++)
			begin
				if (pAddr == regPhase01 + apbAddr_t'(i))
				begin
					settings.phaseDelay[2*i] <= pWdata[15:0];
					settings.phaseDelay[2*i+1] <= pWdata[31:16];
				end
			end
		end
	end

	// readback, valid during the access phase
	always_comb
	begin
		pRdata = '0;
		case (pAddr)
			regControl: pRdata = apbData_t'(ctrlReg);
			regActiveMask: pRdata = apbData_t'(settings.activeMask);
			regCommand: pRdata = apbData_t'(cmdWord);
			regChargeFire: pRdata = {settings.fireDelay, settings.chargeTime};
			regRecvDelay: pRdata = settings.recvTrigDelay;
			regStatus: pRdata = apbData_t'({adcTrigger, busy, interrupt});
			default: ;
		endcase
		for (int i = 0; i < chanCount / 2; i++)
		begin
			if (pAddr == regPhase01 + apbAddr_t'(i))
			begin
				pRdata = {settings.phaseDelay[2*i+1], settings.phaseDelay[2*i]};
			end
		end
	end
endmodule

/* commandDecoder.sv */
module commandDecoder
(
	input logic txCLK,
	input logic rst,
	input txPkg::ctrlMode_e mode,
	input txPkg::cmdWord_t cmdWord,
	output txPkg::txCmd_t cmd
);
	import txPkg::*;

	cmdWord_t prevWord;	// last word seen in pio mode
	txCmd_t newCmd;

	// flags carried by the current word
	always_comb
	begin
		newCmd.fire = cmdWord[cmdBitFire];
		newCmd.issueRecvTrig = cmdWord[cmdBitIssueRecvTrig];
		newCmd.setAmp = cmdWord[cmdBitSetAmp];
		newCmd.setPhase = cmdWord[cmdBitSetPhase];
		newCmd.resetRecvTrig = cmdWord[cmdBitResetRecvTrig];
		newCmd.resetInterrupt = cmdWord[cmdBitResetInterrupt];
	end

	always_ff @(posedge txCLK)
	begin
		if (rst || mode != modePio)
		begin
			prevWord <= '0;
			cmd <= '0;
		end
		else
		begin
			prevWord <= cmdWord;
			if (cmdWord != prevWord)
				cmd <= newCmd;	// one cycle only
			else
				cmd <= '0;
		end
	end
endmodule

/* fireSequencer.sv */
module fireSequencer #(
	parameter int numChannels = 8
)
(
	input logic txCLK,
	input logic rst,
	input txPkg::ctrlMode_e mode,
	input txPkg::txCmd_t cmd,
	input txPkg::txSettings_t settings,
	input logic [numChannels-1:0] channelDone,
	output logic launch,
	output txPkg::chargeTime_t chargeTime,
	output txPkg::phaseDelay_t [txPkg::chanCount-1:0] phaseDelay,
	output logic [txPkg::chanCount-1:0] activeMask,
	output logic busy,
	output logic interrupt
);
	import txPkg::*;

	fireState_e state;
	fireDelay_t delayCnt;

	assign busy = (state != fireIdle);

	always_ff @(posedge txCLK)
	begin
		if (rst || mode != modePio)
		begin
			state <= fireIdle;
			delayCnt <= '0;
			launch <= 1'b0;
			interrupt <= 1'b0;
			chargeTime <= '0;
			phaseDelay <= '0;
			activeMask <= '0;
		end
		else
		begin
			launch <= 1'b0;
			// settings stay frozen during a fire
			if (!busy && cmd.setAmp)
				chargeTime <= settings.chargeTime;
			if (!busy && cmd.setPhase)
				phaseDelay <= settings.phaseDelay;
			if (cmd.resetInterrupt)
				interrupt <= 1'b0;
			case (state)
				fireIdle:
				begin
					if (cmd.fire)
					begin
						activeMask <= settings.activeMask;
						if (settings.fireDelay == '0)
						begin
							launch <= 1'b1;
							state <= fireActive;
						end
						else
						begin
							delayCnt <= settings.fireDelay - 1'b1;
							state <= fireDelay;
						end
					end
				end
				fireDelay:
				begin
					if (delayCnt == '0)
					begin
						launch <= 1'b1;
						state <= fireActive;
					end
					else
						delayCnt <= delayCnt - 1'b1;
				end
				fireActive:
				begin
					// done vector still shows the previous fire while launch is up
					if (!launch && &channelDone)
					begin
						state <= fireIdle;
						interrupt <= 1'b1;
					end
				end
				default: state <= fireIdle;
			endcase
		end
	end
endmodule

/* pulseChannel.sv */
module pulseChannel
(
	input logic txCLK,
	input logic rst,
	input logic abort,
	input logic launch,
	input logic active,
	input txPkg::chargeTime_t chargeTime,
	input txPkg::phaseDelay_t phaseDelay,
	output logic pulseOut,
	output logic done
);
	import txPkg::*;

	typedef enum logic [1:0] {chIdle, chWait, chPulse, chDone} chState_e;

	chState_e state;
	phaseDelay_t cnt;	// phase wait, then charge time
	logic startNow;

	// pulse begins on launch with zero phase, or when the wait runs out
	assign startNow = launch ? (active && phaseDelay == '0) : (state == chWait && cnt == '0);
	assign pulseOut = (state == chPulse);
	assign done = (state == chDone);

	always_ff @(posedge txCLK)
	begin
		if (rst || abort)
		begin
			state <= chIdle;
			cnt <= '0;
		end
		else if (startNow)
		begin
			if (chargeTime == '0)
				state <= chDone;	// nothing to drive
			else
			begin
				state <= chPulse;
				cnt <= phaseDelay_t'(chargeTime) - 1'b1;
			end
		end
		else if (launch)
		begin
			state <= active ? chWait : chDone;
			cnt <= phaseDelay - 1'b1;
		end
		else if (state == chWait)
			cnt <= cnt - 1'b1;
		else if (state == chPulse)
		begin
			if (cnt == '0)
				state <= chDone;
			else
				cnt <= cnt - 1'b1;
		end
	end
endmodule

/* recvTrigger.sv */
module recvTrigger
(
	input logic txCLK,
	input logic rst,
	input txPkg::ctrlMode_e mode,
	input txPkg::txCmd_t cmd,
	input txPkg::recvDelay_t recvDelay,
	input logic adcAck,
	output logic adcTrigger
);
	import txPkg::*;

	logic timerRun;
	logic [1:0] trigFlags;	// [0] line raised, [1] ack seen
	recvDelay_t delayCnt;

	always_ff @(posedge txCLK)
	begin
		if (rst || mode != modePio)
		begin
			timerRun <= 1'b0;
			trigFlags <= 2'b00;
			delayCnt <= '0;
			adcTrigger <= 1'b0;
		end
		else
		begin
			// one issue per re-arm
			if (cmd.issueRecvTrig && !timerRun && trigFlags == 2'b00)
			begin
				if (recvDelay != '0)
				begin
					timerRun <= 1'b1;
					delayCnt <= recvDelay - 1'b1;
				end
				else
				begin
					adcTrigger <= 1'b1;
					trigFlags[0] <= 1'b1;
				end
			end
			else if (timerRun)
			begin
				if (delayCnt == '0)
				begin
					adcTrigger <= 1'b1;
					trigFlags[0] <= 1'b1;
					timerRun <= 1'b0;
				end
				else
					delayCnt <= delayCnt - 1'b1;
			end
			if (trigFlags[0] && !trigFlags[1] && adcAck)
			begin
				adcTrigger <= 1'b0;	// adc has taken it
				trigFlags[1] <= 1'b1;
			end
			if (cmd.resetRecvTrig)
			begin
				adcTrigger <= 1'b0;
				trigFlags <= 2'b00;
				timerRun <= 1'b0;
			end
		end
	end
endmodule

/* txOutputTop.sv */
module txOutputTop #(
	parameter int numChannels = 8
)
(
	input logic txCLK,
	input logic rst,
	input logic pSel,
	input logic pEnable,
	input logic pWrite,
	input txPkg::apbAddr_t pAddr,
	input txPkg::apbData_t pWdata,
	output txPkg::apbData_t pRdata,
	output logic pReady,
	output logic pSlvErr,
	input logic adcAck,
	output logic adcTrigger,
	output logic [numChannels-1:0] transducerOut,
	output logic interrupt
);
	import txPkg::*;

	ctrlMode_e mode;
	txSettings_t settings;
	cmdWord_t cmdWord;
	txCmd_t cmd;
	logic launch;
	chargeTime_t chargeTime;
	phaseDelay_t [chanCount-1:0] phaseDelay;
	logic [chanCount-1:0] activeMask;
	logic busy;
	logic [numChannels-1:0] channelDone;
	logic idleMode;

	assign idleMode = (mode != modePio);	// also covers the unused codes

	apbRegFile uRegFile
	(
		.txCLK(txCLK), .rst(rst), .pSel(pSel), .pEnable(pEnable), .pWrite(pWrite),
		.pAddr(pAddr), .pWdata(pWdata), .pRdata(pRdata), .pReady(pReady),
		.pSlvErr(pSlvErr), .busy(busy), .interrupt(interrupt), .adcTrigger(adcTrigger),
		.mode(mode), .settings(settings), .cmdWord(cmdWord)
	);

	commandDecoder uCmdDecoder
	(
		.txCLK(txCLK), .rst(rst), .mode(mode), .cmdWord(cmdWord), .cmd(cmd)
	);

	fireSequencer #(.numChannels(numChannels)) uFireSeq
	(
		.txCLK(txCLK), .rst(rst), .mode(mode), .cmd(cmd), .settings(settings),
		.channelDone(channelDone), .launch(launch), .chargeTime(chargeTime),
		.phaseDelay(phaseDelay), .activeMask(activeMask), .busy(busy),
		.interrupt(interrupt)
	);

	recvTrigger uRecvTrig
	(
		.txCLK(txCLK), .rst(rst), .mode(mode), .cmd(cmd),
		.recvDelay(settings.recvTrigDelay), .adcAck(adcAck), .adcTrigger(adcTrigger)
	);

	for (genvar ch = 0; ch < numChannels; ch++)
	begin : gChannel
		pulseChannel uChannel
		(
			.txCLK(txCLK), .rst(rst), .abort(idleMode), .launch(launch),
			.active(activeMask[ch]), .chargeTime(chargeTime), .phaseDelay(phaseDelay[ch]),
			.pulseOut(transducerOut[ch]), .done(channelDone[ch])
		);
	end
endmodule

/* txOutput_assertions.sv */
module txOutputAssertions
(
	input logic txCLK,
	input logic rst,
	input logic idleMode,
	input logic pReady,
	input logic launch,
	input logic adcTrigger,
	input logic [txPkg::chanCount-1:0] transducerOut
);
	timeunit 1ns;
	timeprecision 100ps;

	// outputs clear one cycle after idle is entered
	quietInIdle: assert property (@(posedge txCLK) disable iff (rst)
		(idleMode && $past(idleMode)) |-> (!adcTrigger && transducerOut == '0))
		else $error("transducer or trigger output active in idle mode");

	alwaysReady: assert property (@(posedge txCLK) pReady)
		else $error("pReady went low");

	launchOneCycle: assert property (@(posedge txCLK) disable iff (rst) launch |=> !launch)
		else $error("launch held longer than one cycle");
endmodule

/* txOutputTb.sv */
module txOutputTb;
	timeunit 1ns;
	timeprecision 100ps;
	import txPkg::*;

	localparam int numChannels = 8;
	localparam int waitLimit = 2000;
	localparam apbData_t cmdIssue = 32'h02;
	localparam apbData_t cmdFire = 32'h04;
	localparam apbData_t cmdLoadFire = 32'h34;	// setPhase, setAmp and fire together
	localparam apbData_t cmdResetRecv = 32'h40;
	localparam apbData_t cmdResetIrq = 32'h80;
	localparam logic [7:0] activeSet = 8'b1101_0111;	// channels 3 and 5 off
	localparam chargeTime_t chargeVal = 9'd12;

	logic txCLK = 1'b0;
	logic rst;
	logic pSel;
	logic pEnable;
	logic pWrite;
	logic pReady;
	logic pSlvErr;
	logic adcAck;
	logic adcTrigger;
	logic interrupt;
	apbAddr_t pAddr;
	apbData_t pWdata;
	apbData_t pRdata;
	logic [numChannels-1:0] transducerOut;
	phaseDelay_t phase [numChannels];
	int seed = 79;
	logic lastSlvErr;

	txOutputTop #(.numChannels(numChannels)) u_dut (.*);

	bind txOutputTop txOutputAssertions uChecks
	(
		.txCLK(txCLK), .rst(rst), .idleMode(idleMode), .pReady(pReady), .launch(launch),
		.adcTrigger(adcTrigger), .transducerOut(transducerOut)
	);

	always #2 txCLK = ~txCLK;

	task automatic stopOnFailure();
		$display("sim failed");
		$fatal(1, "stopped at first failure");
	endtask

	task automatic checkValue(string testName, apbData_t expected, apbData_t actual);
		if (expected !== actual)
		begin
			$display("[ERROR] %s: expected 0x%0h, actual 0x%0h", testName, expected, actual);
			stopOnFailure();
		end
	endtask

	task automatic apbAccess(input logic write, input apbAddr_t addr, input apbData_t wdata,
		output apbData_t rdata);
		int waitCnt;
		@(negedge txCLK);
		pSel = 1'b1;
		pEnable = 1'b0;
		pWrite = write;
		pAddr = addr;
		pWdata = wdata;
		@(negedge txCLK);
		pEnable = 1'b1;
		waitCnt = 0;
		#1;
		while (!pReady)
		begin
			if (waitCnt >= waitLimit)
			begin
				$display("timeout while waiting for pReady");
				stopOnFailure();
			end
			@(negedge txCLK);
			#1;
			waitCnt++;
		end
		rdata = pRdata;	// sampled mid access phase
		lastSlvErr = pSlvErr;
		@(negedge txCLK);
		pSel = 1'b0;
		pEnable = 1'b0;
		pWrite = 1'b0;
	endtask

	task automatic apbWrite(apbAddr_t addr, apbData_t data);
		apbData_t unused;
		apbAccess(1'b1, addr, data, unused);
	endtask

	task automatic apbRead(input apbAddr_t addr, output apbData_t data);
		apbAccess(1'b0, addr, '0, data);
	endtask

	// cycles counted from the negedge after the write edge
	task automatic waitLevel(input bit onTrigger, input logic level, output int cycles);
		cycles = 0;
		while ((onTrigger ? adcTrigger : interrupt) !== level)
		begin
			if (cycles >= waitLimit)
			begin
				$display("timeout while waiting for %s", onTrigger ? "adcTrigger" : "interrupt");
				stopOnFailure();
			end
			@(negedge txCLK);
			cycles++;
		end
	endtask

	task automatic watchQuiet(string testName, int cycles);
		repeat (cycles)
		begin
			@(negedge txCLK);
			checkValue(testName, 0, {adcTrigger, transducerOut});
		end
	endtask

	task automatic fireAndCheck(string testName);
		int riseAt [numChannels];
		int highCnt [numChannels];
		int cycle;
		apbData_t rd;
		for (int ch = 0; ch < numChannels; ch++)
		begin
			riseAt[ch] = -1;
			highCnt[ch] = 0;
		end
		apbWrite(regCommand, cmdLoadFire);
		cycle = 0;
		while (!interrupt)
		begin
			if (cycle >= waitLimit)
			begin
				$display("timeout, interrupt never rose after the fire command");
				stopOnFailure();
			end
			@(negedge txCLK);
			cycle++;
			for (int ch = 0; ch < numChannels; ch++)
			begin
				if (transducerOut[ch])
				begin
					if (highCnt[ch] == 0)
						riseAt[ch] = cycle;
					highCnt[ch]++;
				end
			end
		end
		for (int ch = 0; ch < numChannels; ch++)
		begin
			if (activeSet[ch])
			begin
				checkValue($sformatf("%s ch%0d high time", testName, ch), chargeVal, highCnt[ch]);
				// write edge to launch is 2, launch to rise is 1 + phase
				checkValue($sformatf("%s ch%0d rise", testName, ch), 3 + phase[ch], riseAt[ch]);
				checkValue($sformatf("%s ch%0d offset", testName, ch),
					int'(phase[ch]) - int'(phase[0]), riseAt[ch] - riseAt[0]);
			end
			else
				checkValue($sformatf("%s ch%0d inactive", testName, ch), 0, highCnt[ch]);
		end
		apbRead(regStatus, rd);
		checkValue({testName, " status interrupt"}, 1, rd[0]);
		checkValue({testName, " status busy"}, 0, rd[1]);
		checkValue({testName, " interrupt port"}, 1, interrupt);
	endtask

	task automatic registerAccess();
		apbData_t rd;
		checkValue("reset outputs", 0, {adcTrigger, interrupt, transducerOut});
		apbRead(regStatus, rd);
		checkValue("reset status", 0, rd);
		apbRead(regControl, rd);
		checkValue("reset control", 0, rd);
		apbWrite(regActiveMask, 32'h5a);
		apbRead(regActiveMask, rd);
		checkValue("activeMask readback", 32'h5a, rd);
		// phase, charge/fire and receive delay registers hold full words
		for (int a = 3; a <= 8; a++)
		begin
			apbWrite(apbAddr_t'(a), 32'h9e37_79b9 * a);
			checkValue("good write slave error", 0, lastSlvErr);
			apbRead(apbAddr_t'(a), rd);
			checkValue($sformatf("readback addr %0d", a), 32'h9e37_79b9 * a, rd);
		end
		apbRead(4'd12, rd);
		checkValue("bad address slave error", 1, lastSlvErr);
		apbWrite(regStatus, 32'h7);
		checkValue("status write slave error", 1, lastSlvErr);
	endtask

	task automatic fireTest();
		for (int i = 0; i < numChannels; i++)
			phase[i] = phaseDelay_t'($random(seed) & 32'h3f);	// short delays
		for (int i = 0; i < numChannels / 2; i++)
			apbWrite(regPhase01 + apbAddr_t'(i), {phase[2*i+1], phase[2*i]});
		apbWrite(regChargeFire, {23'd0, chargeVal});
		apbWrite(regActiveMask, {24'd0, activeSet});
		apbWrite(regControl, 32'd1);	// pio
		fireAndCheck("fire");
	endtask

	task automatic commandEdge();
		apbData_t rd;
		int cycles;
		apbWrite(regCommand, cmdLoadFire);	// same word again
		watchQuiet("repeated word", 60);
		apbRead(regStatus, rd);
		checkValue("repeated word status", 32'h1, rd);
		apbWrite(regCommand, cmdResetIrq);
		waitLevel(1'b0, 1'b0, cycles);
		apbRead(regStatus, rd);
		checkValue("interrupt cleared", 0, rd[0]);
		fireAndCheck("refire");
	endtask

	task automatic recvTriggerTest();
		int cycles;
		apbWrite(regRecvDelay, 32'd0);
		apbWrite(regCommand, cmdIssue);
		waitLevel(1'b1, 1'b1, cycles);
		checkValue("issue delay 0 rise", 2, cycles);
		adcAck = 1'b1;
		waitLevel(1'b1, 1'b0, cycles);
		checkValue("ack drop", 1, cycles);
		adcAck = 1'b0;
		// no re-arm yet, so this issue is ignored
		apbWrite(regCommand, 32'd0);
		apbWrite(regCommand, cmdIssue);
		watchQuiet("issue without re-arm", 40);
		apbWrite(regCommand, cmdResetRecv);
		apbWrite(regRecvDelay, 32'd20);
		apbWrite(regCommand, cmdIssue);
		waitLevel(1'b1, 1'b1, cycles);
		checkValue("delayed rise not early", 1, cycles >= 20);
		checkValue("delayed rise", 22, cycles);
		adcAck = 1'b1;
		waitLevel(1'b1, 1'b0, cycles);
		adcAck = 1'b0;
	endtask

	task automatic abortTest();
		apbData_t rd;
		int cycles;
		apbWrite(regCommand, cmdResetIrq);
		waitLevel(1'b0, 1'b0, cycles);
		apbWrite(regChargeFire, {23'd1000, chargeVal});	// launch far away
		apbWrite(regCommand, cmdFire);
		apbRead(regStatus, rd);
		checkValue("abort busy before idle", 1, rd[1]);
		apbWrite(regControl, 32'd0);
		watchQuiet("abort outputs", 1100);
		apbRead(regStatus, rd);
		checkValue("abort status", 0, rd);
	endtask

	initial
	begin
		rst = 1'b1;
		pSel = 1'b0;
		pEnable = 1'b0;
		pWrite = 1'b0;
		pAddr = '0;
		pWdata = '0;
		adcAck = 1'b0;
		repeat (8) @(posedge txCLK);
		@(negedge txCLK);
		rst = 1'b0;
		registerAccess();
		fireTest();
		commandEdge();
		recvTriggerTest();
		abortTest();
		$display("sim passed");
		$finish;
	end
endmodule

/* vlog.f */
txPkg.sv
apbRegFile.sv
commandDecoder.sv
fireSequencer.sv
pulseChannel.sv
recvTrigger.sv
txOutputTop.sv
txOutput_assertions.sv
txOutputTb.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module txOutputTb \
	-o txOutputSim > sim.log 2>&1 \
	&& ./obj_dir/txOutputSim >> sim.log 2>&1 \
	|| echo "sim failed" >> sim.log
if grep -q "sim failed" sim.log; then
	echo "FAIL, see sim.log"
	exit 1
fi
echo "PASS"
